// File: list.f
hdl/vid_pkg.sv
hdl/vid_timing.sv
hdl/vid_char.sv
hdl/vid_scroll.sv
hdl/vid_rom_arb.sv
hdl/vid_colmix.sv
hdl/vid_top.sv
verification/tb_clock.sv
verification/tb_top.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --top-module tb_top -f list.f -Mdir obj_dir
	./obj_dir/Vtb_top | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_top.sv
// Tile video testbench

`default_nettype none

module tb_top
    import vid_pkg::*;
;

localparam int FRAMES = 16;
localparam int LIMIT  = FRAMES * 48 * 24 * 4 * 8 + 50000;

logic clk, reset, pxl_cen, cpu_wr, char_cs, scr_cs, pal_cs, rom_ok, rom_cs;
logic hbl, vbl, hs, vs, lhbl_dly, lvbl_dly;
logic [7:0] cpu_addr, cpu_din;
logic [5:0] scrhpos;
logic [4:0] scrvpos;
logic [ROM_AW-1:0] rom_addr;
logic [ROM_DW-1:0] rom_data;
logic [3:0] red, green, blue;
logic [1:0] cen_cnt;

logic [7:0] char_m [8];    // Copies of what the CPU wrote
logic [7:0] scr_m [32];
logic [7:0] pal_m [64];
logic [5:0] scrh_m;
logic [4:0] scrv_m;

integer seed;
int errors, tests_failed, timing_errs, blank_errs, n_clear, n_solid;
int px, py, hs_run, vs_run, hb_run, delay, start_err, tick;
logic lhbl_prev, lvbl_prev, check_en, bad;

tb_clock u_clock(.clk(clk), .reset(reset));

vid_top dut0(
    .clk(clk), .reset(reset), .pxl_cen(pxl_cen),
    .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_wr(cpu_wr),
    .char_cs(char_cs), .scr_cs(scr_cs), .pal_cs(pal_cs),
    .scrhpos(scrhpos), .scrvpos(scrvpos),
    .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
    .hbl(hbl), .vbl(vbl), .hs(hs), .vs(vs),
    .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly),
    .red(red), .green(green), .blue(blue)
);

// Fixed hash of the ROM address
function automatic logic [15:0] rom_word(input logic [ROM_AW-1:0] addr);
    logic [31:0] h;
    h = {19'd0, addr} * 32'h9e3779b1;
    h = h ^ (h >> 15);
    h = h * 32'h000085eb;
    return h[15:0] ^ h[31:16];
endfunction

function automatic logic [3:0] char_nibble(input int h, input int v);
    logic [5:0] hh;
    logic [4:0] vv;
    logic [15:0] w;
    hh = 6'(h);
    vv = 5'(v);
    w  = rom_word({1'b0, char_m[{vv[3], hh[4:3]}], vv[2:0], hh[2]});
    return w[{hh[1:0], 2'b00} +: 4];
endfunction

// World position wraps at 64 by 32
function automatic logic [3:0] scroll_nibble(input int h, input int v);
    logic [5:0] wx;
    logic [4:0] wy;
    logic [15:0] w;
    wx = 6'(h) + scrh_m;
    wy = 5'(v) + scrv_m;
    w  = rom_word({1'b1, scr_m[{wy[4:3], wx[5:3]}], wy[2:0], wx[2]});
    return w[{wx[1:0], 2'b00} +: 4];
endfunction

// Expected {red, green, blue} for a visible position
function automatic logic [11:0] ref_pixel(input int h, input int v);
    logic [3:0] cp;
    logic [4:0] idx;
    logic [7:0] lo;
    logic [7:0] hi;
    cp  = char_nibble(h, v);
    idx = (cp == 4'd0) ? {1'b1, scroll_nibble(h, v)} : {1'b0, cp};
    lo  = pal_m[{idx, 1'b0}];
    hi  = pal_m[{idx, 1'b1}];
    return {lo[3:0], lo[7:4], hi[3:0]};
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp, output logic mism);
    mism = (got !== exp);
    if (mism) begin
        errors++;
        $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic cpu_write(input int sel, input int addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    cpu_addr = 8'(addr);
    cpu_din  = data;
    cpu_wr   = 1'b1;
    char_cs  = (sel == 0);
    scr_cs   = (sel == 1);
    pal_cs   = (sel == 2);
endtask

task automatic cpu_idle();
    @(posedge clk);
    #1;
    cpu_wr  = 1'b0;
    char_cs = 1'b0;
    scr_cs  = 1'b0;
    pal_cs  = 1'b0;
endtask

task automatic pal_set(input int idx, input logic [11:0] col);   // col is {r, g, b}
    pal_m[2*idx]   = {col[7:4], col[11:8]};
    pal_m[2*idx+1] = {4'h0, col[3:0]};
    cpu_write(2, 2*idx, pal_m[2*idx]);
    cpu_write(2, 2*idx+1, pal_m[2*idx+1]);
endtask

task automatic load_maps(input bit zero);
    for (int i = 0; i < 8; i++) begin
        char_m[i] = zero ? 8'd0 : 8'($random(seed));
        cpu_write(0, i, char_m[i]);
    end
    for (int i = 0; i < 32; i++) begin
        scr_m[i] = zero ? 8'd0 : 8'($random(seed));
        cpu_write(1, i, scr_m[i]);
    end
    cpu_idle();
endtask

task automatic load_palette(input bit zero, input bit scr_black);
    logic [11:0] col;
    for (int i = 0; i < 32; i++) begin
        col = zero ? 12'd0 : 12'($random(seed));
        if (scr_black && i >= 16) begin
            col = 12'd0;
        end
        pal_set(i, col);
    end
    cpu_idle();
endtask

task automatic set_scroll(input logic [5:0] h, input logic [4:0] v);
    @(posedge clk);
    #1;
    scrhpos = h;
    scrvpos = v;
    scrh_m  = h;
    scrv_m  = v;
endtask

task automatic run_frames(input int n);
    repeat (n) @(posedge vbl);
endtask

task automatic report_test(input int num, input string name, input int nerr);
    if (nerr != 0) begin
        tests_failed++;
    end
    $display("test %0d %s: %s (%0d errors)", num, name, (nerr == 0) ? "ok" : "FAILED", nerr);
endtask

// Pixel enable every 4 clocks
always @(posedge clk) begin
    #1;
    cen_cnt = cen_cnt + 2'd1;
    pxl_cen = (cen_cnt == 2'd0);
end

// ROM model with 1 to 3 clocks of latency
always @(posedge clk) begin
    if (rom_cs && !reset) begin
        delay = 1 + ($unsigned($random(seed)) % 3);
        repeat (delay - 1) @(posedge clk);
        #1;
        rom_data = rom_word(rom_addr);
        rom_ok   = 1'b1;
        @(posedge clk);
        #1;
        rom_ok   = 1'b0;
        rom_data = 16'hxxxx;
    end
end

// Compare process, one sample per pixel tick once outputs settle
always @(posedge clk) begin
    if (pxl_cen && !reset) begin
        @(negedge clk);
        if (lhbl_dly && !lhbl_prev) begin
            px = 0;
            py = (lvbl_dly && !lvbl_prev) ? 0 : py + 1;
        end else begin
            px = px + 1;
        end
        tick++;   // Screen position counted from 0,0 at reset
        check_value("hbl", 32'(hbl), 32'((tick % int'(H_TOTAL)) >= int'(H_VIS)), bad);
        timing_errs += int'(bad);
        check_value("vbl", 32'(vbl),
                    32'(((tick / int'(H_TOTAL)) % int'(V_TOTAL)) >= int'(V_VIS)), bad);
        timing_errs += int'(bad);
        if (hs) begin
            hs_run++;
        end else if (hs_run != 0) begin
            check_value("hs_width", 32'(hs_run), 32'(HS_END - HS_START), bad);
            timing_errs += int'(bad);
            hs_run = 0;
        end
        if (vs) begin
            vs_run++;
        end else if (vs_run != 0) begin   // Width in ticks, whole lines
            check_value("vs_width", 32'(vs_run), 32'(VS_END - VS_START) * 32'(H_TOTAL), bad);
            timing_errs += int'(bad);
            vs_run = 0;
        end
        if (lhbl_dly) begin
            hb_run++;
        end else if (hb_run != 0) begin
            check_value("lhbl_dly_width", 32'(hb_run), 32'(H_VIS), bad);
            timing_errs += int'(bad);
            hb_run = 0;
        end
        if (check_en) begin
            if (lhbl_dly && lvbl_dly) begin
                check_value($sformatf("rgb(%0d,%0d)", px, py), 32'({red, green, blue}),
                            32'(ref_pixel(px, py)), bad);
                if (char_nibble(px, py) == 4'd0) begin
                    n_clear++;
                end else begin
                    n_solid++;
                end
            end else begin
                check_value("rgb_blank", 32'({red, green, blue}), 32'd0, bad);
                blank_errs += int'(bad);
            end
        end
        lhbl_prev = lhbl_dly;
        lvbl_prev = lvbl_dly;
    end
end

initial begin
    #(LIMIT);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
end

initial begin
    seed = 32'h251be6c0;
    {cpu_wr, char_cs, scr_cs, pal_cs, rom_ok, check_en} = 6'd0;
    {cpu_addr, cpu_din} = 16'd0;
    {scrhpos, scrvpos, scrh_m, scrv_m} = 22'd0;
    rom_data = 16'd0;
    pxl_cen = 1'b0;
    cen_cnt = 2'd0;
    {errors, tests_failed, timing_errs, blank_errs, n_clear, n_solid} = 192'd0;
    {px, py, hs_run, vs_run, hb_run, tick} = 192'd0;
    {lhbl_prev, lvbl_prev} = 2'b00;
    wait (!reset);
    @(posedge vbl);

    start_err = errors;
    load_maps(1'b1);
    load_palette(1'b1, 1'b0);
    check_en = 1'b1;
    run_frames(1);
    report_test(1, "timing", timing_errs + errors - start_err);

    start_err = errors;
    load_maps(1'b0);
    load_palette(1'b0, 1'b1);   // Scroll colours black
    run_frames(2);
    report_test(2, "char layer", errors - start_err);

    start_err = errors;
    n_clear = 0;
    n_solid = 0;
    load_maps(1'b0);
    load_palette(1'b0, 1'b0);
    run_frames(2);
    if (n_clear == 0 || n_solid == 0) begin
        $display("Priority test saw no mix of clear and solid char pixels");
        errors++;
    end
    report_test(3, "priority", errors - start_err);

    start_err = errors;
    set_scroll(6'd3, 5'd1);
    run_frames(1);
    set_scroll(6'd13, 5'd7);
    run_frames(1);
    set_scroll(6'd60, 5'd30);   // Wraps both ways
    run_frames(1);
    set_scroll(6'd37, 5'd17);
    run_frames(1);
    report_test(4, "scrolling", errors - start_err);

    start_err = errors;
    for (int i = 1; i < 5; i++) begin
        pal_set(i, 12'($random(seed)));
        pal_set(i + 16, 12'($random(seed)));
    end
    cpu_idle();
    run_frames(1);
    report_test(5, "palette update", errors - start_err);

    run_frames(2);
    report_test(6, "blanking", blank_errs);

    $display("%0d tests, %0d failed, %0d errors", 6, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
// Testbench clock and reset

`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // Period 8
end

// Reset held for two rising edges
initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
end

endmodule

`default_nettype wire

// File: hdl/vid_top.sv
// Tile video subsystem

`default_nettype none

module vid_top
    import vid_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               pxl_cen,
    // CPU bus
    input  wire  [7:0]        cpu_addr,
    input  wire  [7:0]        cpu_din,
    input  wire               cpu_wr,
    input  wire               char_cs,
    input  wire               scr_cs,
    input  wire               pal_cs,
    // Scroll offsets
    input  wire  [5:0]        scrhpos,
    input  wire  [4:0]        scrvpos,
    // Shared graphics ROM
    output logic [ROM_AW-1:0] rom_addr,
    output logic              rom_cs,
    input  wire  [ROM_DW-1:0] rom_data,
    input  wire               rom_ok,
    // Video
    output logic              hbl,
    output logic              vbl,
    output logic              hs,
    output logic              vs,
    output logic              lhbl_dly,
    output logic              lvbl_dly,
    output logic [3:0]        red,
    output logic [3:0]        green,
    output logic [3:0]        blue
);

logic [5:0]        hpos;
logic [4:0]        vpos;
logic [3:0]        char_pxl;
logic [3:0]        scr_pxl;
logic              char_req;
logic              char_ok;
logic [ROM_AW-1:0] char_addr;
logic              scr_req;
logic              scr_ok;
logic [ROM_AW-1:0] scr_addr;

vid_timing u_timing(
    .clk      ( clk      ),
    .reset    ( reset    ),
    .pxl_cen  ( pxl_cen  ),
    .hpos     ( hpos     ),
    .vpos     ( vpos     ),
    .hbl      ( hbl      ),
    .vbl      ( vbl      ),
    .hs       ( hs       ),
    .vs       ( vs       )
);

vid_char u_char(
    .clk      ( clk       ),
    .reset    ( reset     ),
    .pxl_cen  ( pxl_cen   ),
    .cpu_addr ( cpu_addr  ),
    .cpu_din  ( cpu_din   ),
    .cpu_wr   ( cpu_wr    ),
    .char_cs  ( char_cs   ),
    .hpos     ( hpos      ),
    .vpos     ( vpos      ),
    .rom_req  ( char_req  ),
    .rom_addr ( char_addr ),
    .rom_data ( rom_data  ),   // Data goes to both, ok strobe is steered
    .rom_ok   ( char_ok   ),
    .char_pxl ( char_pxl  )
);

vid_scroll u_scroll(
    .clk      ( clk       ),
    .reset    ( reset     ),
    .pxl_cen  ( pxl_cen   ),
    .cpu_addr ( cpu_addr  ),
    .cpu_din  ( cpu_din   ),
    .cpu_wr   ( cpu_wr    ),
    .scr_cs   ( scr_cs    ),
    .hpos     ( hpos      ),
    .vpos     ( vpos      ),
    .scrhpos  ( scrhpos   ),
    .scrvpos  ( scrvpos   ),
    .rom_req  ( scr_req   ),
    .rom_addr ( scr_addr  ),
    .rom_data ( rom_data  ),
    .rom_ok   ( scr_ok    ),
    .scr_pxl  ( scr_pxl   )
);

vid_rom_arb u_rom_arb(
    .clk       ( clk       ),
    .reset     ( reset     ),
    .char_req  ( char_req  ),
    .char_addr ( char_addr ),
    .scr_req   ( scr_req   ),
    .scr_addr  ( scr_addr  ),
    .char_ok   ( char_ok   ),
    .scr_ok    ( scr_ok    ),
    .rom_cs    ( rom_cs    ),
    .rom_addr  ( rom_addr  ),
    .rom_ok    ( rom_ok    )
);

vid_colmix u_colmix(
    .clk      ( clk      ),
    .reset    ( reset    ),
    .pxl_cen  ( pxl_cen  ),
    .cpu_addr ( cpu_addr ),
    .cpu_din  ( cpu_din  ),
    .cpu_wr   ( cpu_wr   ),
    .pal_cs   ( pal_cs   ),
    .hbl      ( hbl      ),
    .vbl      ( vbl      ),
    .char_pxl ( char_pxl ),
    .scr_pxl  ( scr_pxl  ),
    .lhbl_dly ( lhbl_dly ),
    .lvbl_dly ( lvbl_dly ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     )
);

endmodule

`default_nettype wire

// File: hdl/vid_colmix.sv
// Colour mixer and palette

`default_nettype none

module vid_colmix
    import vid_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        pxl_cen,
    input  wire  [7:0] cpu_addr,
    input  wire  [7:0] cpu_din,
    input  wire        cpu_wr,
    input  wire        pal_cs,
    input  wire        hbl,
    input  wire        vbl,
    input  wire  [3:0] char_pxl,
    input  wire  [3:0] scr_pxl,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

logic [7:0] pal_ram [64];   // Byte address {index, hi}
logic       char_clear;
logic [4:0] mix_idx;
logic [4:0] pal_idx;
logic       hbl_r;
logic       vbl_r;
logic [7:0] pal_lo;
logic [3:0] pal_blue;

always_ff @(posedge clk) begin
    if (cpu_wr && pal_cs) begin
        pal_ram[cpu_addr[5:0]] <= cpu_din;
    end
end

// Char pixel 0 is see-through
assign char_clear = char_pxl == 4'd0;
assign mix_idx    = {char_clear, char_clear ? scr_pxl : char_pxl};

// First pixel stage, palette index
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        pal_idx <= mix_idx;
    end
end

assign pal_lo   = pal_ram[{pal_idx, 1'b0}];     // Green and red
assign pal_blue = pal_ram[{pal_idx, 1'b1}][3:0];

// Second stage, colour out with blanking
always_ff @(posedge clk) begin
    if (reset) begin
        hbl_r    <= 1'b1;   // Treated as blank before the first pixel
        vbl_r    <= 1'b1;
        lhbl_dly <= 1'b0;
        lvbl_dly <= 1'b0;
        red      <= 4'd0;
        green    <= 4'd0;
        blue     <= 4'd0;
    end else if (pxl_cen) begin
        hbl_r    <= hbl;
        vbl_r    <= vbl;
        lhbl_dly <= !hbl_r;
        lvbl_dly <= !vbl_r;
        if (hbl_r || vbl_r) begin
            red   <= 4'd0;
            green <= 4'd0;
            blue  <= 4'd0;
        end else begin
            red   <= pal_lo[3:0];
            green <= pal_lo[7:4];
            blue  <= pal_blue;
        end
    end
end

endmodule

`default_nettype wire

// File: hdl/vid_rom_arb.sv
// Graphics ROM arbiter

`default_nettype none

module vid_rom_arb
    import vid_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               char_req,
    input  wire  [ROM_AW-1:0] char_addr,
    input  wire               scr_req,
    input  wire  [ROM_AW-1:0] scr_addr,
    output logic              char_ok,
    output logic              scr_ok,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  wire               rom_ok
);

logic grant_char;
logic grant_scr;
logic idle;

assign idle = !grant_char && !grant_scr;

// Char wins when both ask, a grant stays until the ROM answers
always_ff @(posedge clk) begin
    if (reset) begin
        grant_char <= 1'b0;
        grant_scr  <= 1'b0;
    end else if (idle) begin
        if (char_req) begin
            grant_char <= 1'b1;
        end else if (scr_req) begin
            grant_scr <= 1'b1;
        end
    end else if (rom_ok) begin
        grant_char <= 1'b0;   // Back to idle for a clock
        grant_scr  <= 1'b0;
    end
end

// Chip select drops between accesses, so each word gets its own rise
assign rom_cs   = !idle;
assign rom_addr = grant_scr ? scr_addr : char_addr;

// Done strobe goes to whoever holds the grant
assign char_ok = grant_char && rom_ok;
assign scr_ok  = grant_scr && rom_ok;

endmodule

`default_nettype wire

// File: hdl/vid_scroll.sv
// Scrolling background layer

`default_nettype none

module vid_scroll
    import vid_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               pxl_cen,
    input  wire  [7:0]        cpu_addr,
    input  wire  [7:0]        cpu_din,
    input  wire               cpu_wr,
    input  wire               scr_cs,
    input  wire  [5:0]        hpos,
    input  wire  [4:0]        vpos,
    input  wire  [5:0]        scrhpos,
    input  wire  [4:0]        scrvpos,
    output logic              rom_req,
    output logic [ROM_AW-1:0] rom_addr,
    input  wire  [ROM_DW-1:0] rom_data,
    input  wire               rom_ok,
    output logic [3:0]        scr_pxl
);

logic [7:0]          scr_map [SCR_COLS*SCR_ROWS];
logic                late_grp;
logic [4:0]          line;
logic [2:0]          tcol;
logic [2:0]          wcol;
logic [4:0]          wy;
logic                start;
logic                half;
logic [7:0]          code_r;
logic [2:0]          row_r;
logic [ROM_DW-1:0]   word0;
logic [ROM_DW-1:0]   word1;
logic [4*ROM_DW-1:0] pxl_buf;   // Two tiles, lower one is the current group
logic [3:0]          pix_idx;

// Map is {row[1:0], col[2:0]}
always_ff @(posedge clk) begin
    if (cpu_wr && scr_cs) begin
        scr_map[cpu_addr[4:0]] <= cpu_din;
    end
end

// Group g loads tile column g+2 so the buffer holds g and g+1.
// The two blanked groups bring in columns 0 and 1 of the next line.
assign late_grp = hpos >= H_VIS;

always_comb begin
    if (late_grp) begin
        tcol = {2'b00, hpos[3]};
        line = (vpos == V_TOTAL - 5'd1) ? 5'd0 : vpos + 5'd1;
    end else begin
        tcol = hpos[5:3] + 3'd2;
        line = vpos;
    end
end

assign wcol = tcol + scrhpos[5:3];   // Wraps at 64 pixels
assign wy   = line + scrvpos;        // Wraps at 32 lines

always_ff @(posedge clk) begin
    if (reset) begin
        start   <= 1'b0;
        rom_req <= 1'b0;
        half    <= 1'b0;
    end else begin
        start <= pxl_cen && (hpos[2:0] == 3'd7);
        if (start) begin
            rom_req <= 1'b1;
            half    <= 1'b0;
        end else if (rom_ok) begin
            half <= 1'b1;
            if (half) begin
                rom_req <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        code_r <= scr_map[{wy[4:3], wcol}];
        row_r  <= wy[2:0];
    end
    if (rom_ok) begin
        if (half) begin
            word1 <= rom_data;
        end else begin
            word0 <= rom_data;
        end
    end
    // Upper tile moves down, new tile enters on top
    if (pxl_cen && (hpos[2:0] == 3'd7)) begin
        pxl_buf <= {word1, word0, pxl_buf[4*ROM_DW-1:2*ROM_DW]};
    end
end

assign rom_addr = {1'b1, code_r, row_r, half};

// Fine offset picks across the tile boundary
assign pix_idx = {1'b0, hpos[2:0]} + {1'b0, scrhpos[2:0]};
assign scr_pxl = pxl_buf[{pix_idx, 2'b00} +: 4];

endmodule

`default_nettype wire

// File: hdl/vid_char.sv
// Fixed character layer

`default_nettype none

module vid_char
    import vid_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               pxl_cen,
    input  wire  [7:0]        cpu_addr,
    input  wire  [7:0]        cpu_din,
    input  wire               cpu_wr,
    input  wire               char_cs,
    input  wire  [5:0]        hpos,
    input  wire  [4:0]        vpos,
    output logic              rom_req,
    output logic [ROM_AW-1:0] rom_addr,
    input  wire  [ROM_DW-1:0] rom_data,
    input  wire               rom_ok,
    output logic [3:0]        char_pxl
);

logic [7:0]          char_map [CHAR_COLS*CHAR_ROWS];
logic                last_grp;
logic [2:0]          next_grp;
logic [4:0]          line;
logic [2:0]          map_idx;
logic                start;
logic                half;
logic [7:0]          code_r;
logic [2:0]          row_r;
logic [ROM_DW-1:0]   word0;
logic [ROM_DW-1:0]   word1;
logic [2*ROM_DW-1:0] shifter;

// Map is {row, col}
always_ff @(posedge clk) begin
    if (cpu_wr && char_cs) begin
        char_map[cpu_addr[2:0]] <= cpu_din;
    end
end

assign last_grp = hpos >= H_TOTAL - 6'd8;

// Tile of the group after the current one
always_comb begin
    if (last_grp) begin
        next_grp = 3'd0;    // First group of the next line
        line     = (vpos == V_TOTAL - 5'd1) ? 5'd0 : vpos + 5'd1;
    end else begin
        next_grp = hpos[5:3] + 3'd1;
        line     = vpos;
    end
end

assign map_idx = {line[3], next_grp[1:0]};

// Fetch starts one clock into each group, once hpos has moved on
always_ff @(posedge clk) begin
    if (reset) begin
        start   <= 1'b0;
        rom_req <= 1'b0;
        half    <= 1'b0;
    end else begin
        start <= pxl_cen && (hpos[2:0] == 3'd7);
        if (start) begin
            rom_req <= 1'b1;
            half    <= 1'b0;
        end else if (rom_ok) begin
            half <= 1'b1;
            if (half) begin
                rom_req <= 1'b0;    // Both halves in
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        code_r <= char_map[map_idx];   // Held for the whole fetch
        row_r  <= line[2:0];
    end
    if (rom_ok) begin
        if (half) begin
            word1 <= rom_data;
        end else begin
            word0 <= rom_data;
        end
    end
    if (pxl_cen) begin
        shifter <= (hpos[2:0] == 3'd7) ? {word1, word0} : shifter >> 4;
    end
end

assign rom_addr = {1'b0, code_r, row_r, half};
assign char_pxl = shifter[3:0];

endmodule

`default_nettype wire

// File: hdl/vid_timing.sv
// Video timing generator

`default_nettype none

module vid_timing
    import vid_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        pxl_cen,
    output logic [5:0] hpos,
    output logic [4:0] vpos,
    output logic       hbl,
    output logic       vbl,
    output logic       hs,
    output logic       vs
);

logic [5:0] h_nxt;
logic [4:0] v_nxt;
logic       line_end;

assign line_end = hpos == H_TOTAL - 6'd1;

// Next counter values, blank and sync are decoded from these
always_comb begin
    h_nxt = line_end ? 6'd0 : hpos + 6'd1;
    v_nxt = vpos;
    if (line_end) begin
        v_nxt = (vpos == V_TOTAL - 5'd1) ? 5'd0 : vpos + 5'd1;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        hpos <= 6'd0;
        vpos <= 5'd0;
        hbl  <= 1'b0;   // Position 0,0 is visible
        vbl  <= 1'b0;
        hs   <= 1'b0;
        vs   <= 1'b0;
    end else if (pxl_cen) begin
        hpos <= h_nxt;
        vpos <= v_nxt;
        hbl  <= h_nxt >= H_VIS;
        vbl  <= v_nxt >= V_VIS;
        hs   <= (h_nxt >= HS_START) && (h_nxt < HS_END);
        // Vertical sync covers whole lines
        vs   <= (v_nxt >= VS_START) && (v_nxt < VS_END);
    end
end

endmodule

`default_nettype wire

// File: hdl/vid_pkg.sv
// Tile video shared constants

`default_nettype none

package vid_pkg;

    // Horizontal counts, 6 bit counter
    localparam logic [5:0] H_TOTAL  = 6'd48;
    localparam logic [5:0] H_VIS    = 6'd32;   // First blanked count
    localparam logic [5:0] HS_START = 6'd36;
    localparam logic [5:0] HS_END   = 6'd40;   // Exclusive

    // Vertical counts, 5 bit counter
    localparam logic [4:0] V_TOTAL  = 5'd24;
    localparam logic [4:0] V_VIS    = 5'd16;
    localparam logic [4:0] VS_START = 5'd18;
    localparam logic [4:0] VS_END   = 5'd20;   // Exclusive

    // Fixed character map, one byte code per 8x8 tile
    localparam int CHAR_COLS = 4;
    localparam int CHAR_ROWS = 2;

    // Scroll world of 64x32 pixels, wraps both ways
    localparam int SCR_COLS = 8;
    localparam int SCR_ROWS = 4;

    // Graphics ROM word is {layer, code[7:0], row[2:0], half}
    localparam int ROM_AW = 13;
    // Four 4 bit pixels per word, pixel 0 in the low nibble
    localparam int ROM_DW = 16;

    // Pixel ticks from screen position to RGB
    localparam int PXL_DLY = 2;

endpackage

`default_nettype wire
